/* include/bch_defs.svh */
// code parameters for the BCH(31,16) decoder
// field order, code length, correction capability, primitive polynomial

`ifndef BCH_DEFS_SVH
`define BCH_DEFS_SVH

// GF(2^5)
`define BCH_M 5

// full-length code, 16 message bits
`define BCH_N 31

// up to three errors corrected
`define BCH_T 3

// x^5 + x^2 + 1
`define BCH_PRIMPOLY 6'h25

`endif

/* verilog/bch_pkg.sv */
// shared types for the BCH decoder
// field element, syndrome and locator bundles, GF multiply

`include "bch_defs.svh"

package bch_pkg;

	typedef logic [`BCH_M-1:0] gf_elem_t;

	// odd syndromes plus the word they came from
	typedef struct packed {
		gf_elem_t [`BCH_T-1:0] odd;
		logic [`BCH_N-1:0]     word;
	} syn_t;

	// scaled error locator, its degree and the word to correct
	typedef struct packed {
		gf_elem_t [`BCH_T:0] coef;
		logic [1:0]          deg;
		logic [`BCH_N-1:0]   word;
	} loc_t;

	// shift-and-reduce multiply, msb of a first
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t r;
		r = '0;
		for (int i = `BCH_M - 1; i >= 0; i--)
		begin
			r = {r[`BCH_M-2:0], 1'b0} ^ ({`BCH_M{r[`BCH_M-1]}} & gf_elem_t'(`BCH_PRIMPOLY));
			r = r ^ ({`BCH_M{a[i]}} & b);
		end
		return r;
	endfunction

	// alpha^e, for constant multipliers
	function automatic gf_elem_t gf_alpha_pow(input int e);
		gf_elem_t r;
		r = gf_elem_t'(1);
		for (int i = 0; i < e; i++)
		begin
			r = gf_mul(r, gf_elem_t'(2));
		end
		return r;
	endfunction

endpackage

/* verilog/bch_syndrome.sv */
// serial syndrome unit
// Horner accumulators for S1, S3, S5 and a copy of the received word

`timescale 1ns/10ps
`include "bch_defs.svh"

module bch_syndrome (
	input  logic          I_clk,
	input  logic          arst_n,
	input  logic          in_bit,
	input  logic          in_v,
	input  logic          in_sof,
	output bch_pkg::syn_t syn,
	output logic          syn_v
);

	localparam int CNT_W = $clog2(`BCH_N + 1);

	bch_pkg::gf_elem_t [`BCH_T-1:0] acc;
	bch_pkg::gf_elem_t [`BCH_T-1:0] acc_next;
	logic [`BCH_N-1:0]              word_next;
	logic [`BCH_N-1:0]              word;
	logic [CNT_W-1:0]               cnt;
	logic [CNT_W-1:0]               cnt_next;
	logic                           last;

	// ----------------------------------------
	// acc = acc * alpha^(2j+1) + bit
	// ----------------------------------------
	for (genvar j = 0; j < `BCH_T; j++)
	begin : g_acc
		localparam bch_pkg::gf_elem_t ALPHA = bch_pkg::gf_alpha_pow(2 * j + 1);
		bch_pkg::gf_elem_t base;

		// first bit of a frame starts from zero
		assign base = in_sof ? '0 : bch_pkg::gf_mul(acc[j], ALPHA);
		assign acc_next[j] = base ^ {{(`BCH_M-1){1'b0}}, in_bit};
	end

	assign cnt_next = in_sof ? CNT_W'(1) : cnt + CNT_W'(1);
	assign last = in_v && (cnt_next == CNT_W'(`BCH_N));
	// x^30 ends up in the msb
	assign word_next = {word[`BCH_N-2:0], in_bit};

	always_ff @(posedge I_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt <= '0;
			syn_v <= 1'b0;
		end
		else
		begin
			syn_v <= last;
			if (in_v)
				cnt <= cnt_next;
		end
	end

	always_ff @(posedge I_clk)
	begin
		if (in_v)
		begin
			acc <= acc_next;
			word <= word_next;
		end
		if (last)
		begin
			syn.odd <= acc_next;
			syn.word <= word_next;
		end
	end

endmodule

/* verilog/bch_bm.sv */
// inversionless Berlekamp-Massey for binary BCH
// three cycles per iteration: square, discrepancy, update
// even syndromes made on the fly by squaring

`timescale 1ns/10ps
`include "bch_defs.svh"

module bch_bm (
	input  logic          I_clk,
	input  logic          arst_n,
	input  bch_pkg::syn_t syn,
	input  logic          syn_v,
	output bch_pkg::loc_t loc,
	output logic          loc_v
);

	localparam int IT_W = $clog2(`BCH_T);
	// S1 .. S(2T-1)
	localparam int NS = 2 * `BCH_T - 1;

	bch_pkg::gf_elem_t [NS:1]     s;
	bch_pkg::gf_elem_t [`BCH_T:0] v;
	bch_pkg::gf_elem_t [`BCH_T:0] k;
	bch_pkg::gf_elem_t            delta;
	bch_pkg::gf_elem_t            d;
	bch_pkg::gf_elem_t            d_next;
	logic                         deg_big;
	logic                         deg_big_next;
	logic [1:0]                   deg_v;
	logic [`BCH_N-1:0]            word;
	logic                         run;
	logic                         done;
	logic [1:0]                   ph;
	logic [IT_W-1:0]              it;

	// ----------------------------------------
	// discrepancy and degree test
	// ----------------------------------------
	// d = sum of S(2r+1-j) * v_j
	always_comb
	begin
		int idx;
		d_next = '0;
		for (int j = 0; j <= `BCH_T; j++)
		begin
			idx = 2 * int'(it) + 1 - j;
			if (idx >= 1)
				d_next = d_next ^ bch_pkg::gf_mul(s[idx], v[j]);
		end
	end

	// deg v > r
	always_comb
	begin
		deg_big_next = 1'b0;
		for (int j = 1; j <= `BCH_T; j++)
		begin
			if ((v[j] != '0) && (j > int'(it)))
				deg_big_next = 1'b1;
		end
	end

	// highest nonzero coefficient
	always_comb
	begin
		deg_v = 2'd0;
		for (int j = 1; j <= `BCH_T; j++)
		begin
			if (v[j] != '0)
				deg_v = 2'(j);
		end
	end

	// ----------------------------------------
	// sequencing
	// ----------------------------------------
	always_ff @(posedge I_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			run <= 1'b0;
			ph <= 2'd0;
			it <= '0;
			done <= 1'b0;
			loc_v <= 1'b0;
		end
		else
		begin
			done <= run && (ph == 2'd2) && (it == IT_W'(`BCH_T - 1));
			loc_v <= done;
			if (syn_v)
			begin
				run <= 1'b1;
				ph <= 2'd0;
				it <= '0;
			end
			else if (run)
			begin
				if (ph == 2'd2)
				begin
					ph <= 2'd0;
					if (it == IT_W'(`BCH_T - 1))
						run <= 1'b0;
					else
						it <= it + IT_W'(1);
				end
				else
					ph <= ph + 2'd1;
			end
		end
	end

	// ----------------------------------------
	// datapath
	// ----------------------------------------
	always_ff @(posedge I_clk)
	begin
		if (syn_v)
		begin
			for (int i = 0; i < `BCH_T; i++)
				s[2 * i + 1] <= syn.odd[i];
			v <= {{`BCH_T{bch_pkg::gf_elem_t'(0)}}, bch_pkg::gf_elem_t'(1)};
			k <= {{`BCH_T{bch_pkg::gf_elem_t'(0)}}, bch_pkg::gf_elem_t'(1)};
			delta <= bch_pkg::gf_elem_t'(1);
			word <= syn.word;
		end
		else if (run && (ph == 2'd0) && (it != '0))
			// S(2r) = S(r)^2
			s[2 * it] <= bch_pkg::gf_mul(s[it], s[it]);
		else if (run && (ph == 2'd1))
		begin
			d <= d_next;
			deg_big <= deg_big_next;
		end
		else if (run && (ph == 2'd2))
		begin
			// v = delta*v + d*z*k
			v[0] <= bch_pkg::gf_mul(delta, v[0]);
			for (int j = 1; j <= `BCH_T; j++)
				v[j] <= bch_pkg::gf_mul(delta, v[j]) ^ bch_pkg::gf_mul(d, k[j-1]);
			if ((d != '0) && !deg_big)
			begin
				k <= {v[`BCH_T-1:0], bch_pkg::gf_elem_t'(0)};
				delta <= d;
			end
			else
				k <= {k[`BCH_T-2:0], bch_pkg::gf_elem_t'(0), bch_pkg::gf_elem_t'(0)};
		end
		if (done)
		begin
			loc.coef <= v;
			loc.deg <= deg_v;
			loc.word <= word;
		end
	end

endmodule

/* verilog/bch_chien.sv */
// Chien search and output stage
// root test per position, bit correction, root count vs locator degree
// err_cnt and dec_fail update with the last bit of a frame and hold

`timescale 1ns/10ps
`include "bch_defs.svh"

module bch_chien (
	input  logic          I_clk,
	input  logic          arst_n,
	input  bch_pkg::loc_t loc,
	input  logic          loc_v,
	output logic          out_bit,
	output logic          out_v,
	output logic          out_sof,
	output logic [1:0]    err_cnt,
	output logic          dec_fail
);

	localparam int POS_W = $clog2(`BCH_N);

	bch_pkg::gf_elem_t [`BCH_T:0] term;
	bch_pkg::gf_elem_t [`BCH_T:0] term_init;
	bch_pkg::gf_elem_t [`BCH_T:0] term_step;
	bch_pkg::gf_elem_t            sum;
	logic [`BCH_N-1:0]            word;
	logic [1:0]                   deg;
	logic [2:0]                   roots;
	logic [2:0]                   roots_next;
	logic [POS_W-1:0]             pos;
	logic                         act;
	logic                         hit;
	logic                         last;

	// term j walks as lambda_j * alpha^(j*(k+1))
	for (genvar j = 0; j <= `BCH_T; j++)
	begin : g_term
		localparam bch_pkg::gf_elem_t ALPHA = bch_pkg::gf_alpha_pow(j);

		assign term_init[j] = bch_pkg::gf_mul(loc.coef[j], ALPHA);
		assign term_step[j] = bch_pkg::gf_mul(term[j], ALPHA);
	end

	always_comb
	begin
		sum = '0;
		for (int j = 0; j <= `BCH_T; j++)
			sum = sum ^ term[j];
	end

	// zero sum means position 30-k is in error
	assign hit = act && (sum == '0);
	assign last = act && (pos == POS_W'(`BCH_N - 1));
	assign roots_next = roots + {2'b00, hit};

	always_ff @(posedge I_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			act <= 1'b0;
			pos <= '0;
			roots <= '0;
			out_v <= 1'b0;
			out_sof <= 1'b0;
			err_cnt <= 2'd0;
			dec_fail <= 1'b0;
		end
		else
		begin
			out_v <= act;
			out_sof <= act && (pos == '0);
			if (last)
			begin
				err_cnt <= deg;
				dec_fail <= (roots_next != {1'b0, deg});
			end
			// a new frame may load on the last step of the previous one
			if (loc_v)
			begin
				act <= 1'b1;
				pos <= '0;
				roots <= '0;
			end
			else if (act)
			begin
				roots <= roots_next;
				if (last)
					act <= 1'b0;
				else
					pos <= pos + POS_W'(1);
			end
		end
	end

	always_ff @(posedge I_clk)
	begin
		out_bit <= word[`BCH_N-1] ^ hit;
		if (loc_v)
		begin
			term <= term_init;
			word <= loc.word;
			deg <= loc.deg;
		end
		else if (act)
		begin
			term <= term_step;
			word <= {word[`BCH_N-2:0], 1'b0};
		end
	end

endmodule

/* verilog/bch_dec.sv */
// BCH(31,16) decoder top
// syndrome unit, Berlekamp-Massey solver and Chien search in a chain

`timescale 1ns/10ps
`include "bch_defs.svh"

module bch_dec (
	input  logic       I_clk,
	input  logic       arst_n,
	input  logic       in_bit,
	input  logic       in_v,
	input  logic       in_sof,
	output logic       out_bit,
	output logic       out_v,
	output logic       out_sof,
	output logic [1:0] err_cnt,
	output logic       dec_fail
);

	bch_pkg::syn_t syn;
	logic          syn_v;
	bch_pkg::loc_t loc;
	logic          loc_v;

	bch_syndrome bch_syndrome_i (
		.I_clk  (I_clk),
		.arst_n (arst_n),
		.in_bit (in_bit),
		.in_v   (in_v),
		.in_sof (in_sof),
		.syn    (syn),
		.syn_v  (syn_v)
	);

	// 11 cycles from syn_v to loc_v
	bch_bm bch_bm_i (
		.I_clk  (I_clk),
		.arst_n (arst_n),
		.syn    (syn),
		.syn_v  (syn_v),
		.loc    (loc),
		.loc_v  (loc_v)
	);

	bch_chien bch_chien_i (
		.I_clk    (I_clk),
		.arst_n   (arst_n),
		.loc      (loc),
		.loc_v    (loc_v),
		.out_bit  (out_bit),
		.out_v    (out_v),
		.out_sof  (out_sof),
		.err_cnt  (err_cnt),
		.dec_fail (dec_fail)
	);

endmodule

/* bench/bch_clk_gen.sv */
// free-running testbench clock, 4 ns period

`timescale 1ns/10ps

module bch_clk_gen (
	output logic I_clk
);

	initial
	begin
		I_clk = 1'b0;
		forever
			#2 I_clk = ~I_clk;
	end

endmodule

/* bench/bch_dec_tb.sv */
// testbench for the BCH(31,16) decoder
// LFSR stimulus, GF(2) encoder model, output monitor and compare tasks
// clean, corrupted, back-to-back and gapped frames

`timescale 1ns/10ps
`include "bch_defs.svh"

module bch_dec_tb;

	localparam logic [`BCH_N-1:0] GEN_POLY = 'o107657;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;
	localparam int LATENCY = 14;
	localparam int N_FRAMES = 1 + 20 + 60 + 30 + 20;
	localparam int MAX_CYCLES = N_FRAMES * 60 + 200;
	localparam int DRAIN_LIMIT = 60;
	localparam int KIND_CLEAN = 0;
	localparam int KIND_ERR = 1;
	localparam int KIND_B2B = 2;
	localparam int KIND_GAPS = 3;

	logic       I_clk;
	logic       arst_n;
	logic       in_bit;
	logic       in_v;
	logic       in_sof;
	logic       out_bit;
	logic       out_v;
	logic       out_sof;
	logic [1:0] err_cnt;
	logic       dec_fail;

	logic [31:0]       lfsr = 32'hb58c4281;
	int                cyc = 0;
	int                errors = 0;
	int                n_tests = 0;
	int                frames_sent = 0;
	int                frames_done = 0;
	int                frames_seen = 0;
	logic [`BCH_N-1:0] exp_word_q[$];
	int                exp_cnt_q[$];
	int                last_cyc_q[$];
	logic [`BCH_N-1:0] cur_word;
	int                cur_cnt;
	int                bit_idx;
	bit                in_frame = 1'b0;

	bch_clk_gen clk_gen_i (.I_clk(I_clk));

	bch_dec bch_dec_i (
		.I_clk    (I_clk),
		.arst_n   (arst_n),
		.in_bit   (in_bit),
		.in_v     (in_v),
		.in_sof   (in_sof),
		.out_bit  (out_bit),
		.out_v    (out_v),
		.out_sof  (out_sof),
		.err_cnt  (err_cnt),
		.dec_fail (dec_fail)
	);

	// ----------------------------------------
	// random source and code model
	// ----------------------------------------
	function automatic logic rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ LFSR_TAPS;
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[30:0], rand_bit()};
		return r;
	endfunction

	// c(x) = m(x) * g(x) over GF(2)
	function automatic logic [`BCH_N-1:0] encode(input logic [15:0] msg);
		logic [`BCH_N-1:0] cw;
		cw = '0;
		for (int i = 0; i < 16; i++)
		begin
			if (msg[i])
				cw = cw ^ (GEN_POLY << i);
		end
		return cw;
	endfunction

	task automatic build_frame(input int n_err, output logic [`BCH_N-1:0] tx,
		output logic [`BCH_N-1:0] cw);
		logic [`BCH_N-1:0] mask;
		int pos;
		cw = encode(16'(rand_bits(16)));
		mask = '0;
		// distinct error positions
		for (int e = 0; e < n_err; e++)
		begin
			pos = `BCH_N;
			while (pos >= `BCH_N || mask[pos])
				pos = int'(rand_bits(5));
			mask[pos] = 1'b1;
		end
		tx = cw ^ mask;
	endtask

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_status(input logic [1:0] got_cnt, input logic got_fail,
		input logic [1:0] exp_cnt, input logic exp_fail);
		if (got_cnt !== exp_cnt)
		begin
			$display("CHECK FAILED at %0t: err_cnt got %0h expected %0h", $time, got_cnt, exp_cnt);
			errors++;
		end
		if (got_fail !== exp_fail)
		begin
			$display("CHECK FAILED at %0t: dec_fail got %0h expected %0h", $time, got_fail,
				exp_fail);
			errors++;
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp)
		begin
			$display("CHECK FAILED at %0t: out_sof latency got %0d expected %0d", $time, got, exp);
			errors++;
		end
	endtask

	// ----------------------------------------
	// cycle counter and run limit
	// ----------------------------------------
	always @(posedge I_clk)
	begin
		cyc <= cyc + 1;
		if (cyc >= MAX_CYCLES)
		begin
			$display("timeout after %0d cycles, decoder output never completed", cyc);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// output monitor, samples 1 ns after the edge
	always @(posedge I_clk)
	begin
		#1;
		if (frames_seen == 0 && !out_v)
		begin
			check_bit("out_sof", out_sof, 1'b0);
			check_status(err_cnt, dec_fail, 2'd0, 1'b0);
		end
		if (out_v)
		begin
			if (out_sof)
			begin
				if (in_frame)
				begin
					$display("output frame cut short at %0t", $time);
					errors++;
				end
				if (exp_word_q.size() == 0)
				begin
					$display("output frame at %0t with no frame sent", $time);
					errors++;
					in_frame = 1'b0;
				end
				else
				begin
					cur_word = exp_word_q.pop_front();
					cur_cnt = exp_cnt_q.pop_front();
					check_latency(cyc - last_cyc_q.pop_front(), LATENCY);
					in_frame = 1'b1;
					bit_idx = 0;
					frames_seen++;
				end
			end
			else if (!in_frame)
			begin
				$display("out_v high without out_sof at %0t", $time);
				errors++;
			end
			if (in_frame)
			begin
				check_bit($sformatf("out_bit[%0d]", `BCH_N - 1 - bit_idx), out_bit,
					cur_word[`BCH_N-1-bit_idx]);
				// status is updated with the last bit
				if (bit_idx == `BCH_N - 1)
				begin
					check_status(err_cnt, dec_fail, 2'(cur_cnt), 1'b0);
					in_frame = 1'b0;
					frames_done++;
				end
				else
					bit_idx++;
			end
		end
		else if (in_frame)
		begin
			$display("out_v dropped inside an output frame at %0t", $time);
			errors++;
			in_frame = 1'b0;
		end
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge I_clk);
			#0.5;
			in_v = 1'b0;
			in_sof = 1'b0;
		end
	endtask

	task automatic send_frame(input logic [`BCH_N-1:0] tx, input logic [`BCH_N-1:0] cw,
		input int n_err, input bit gaps);
		for (int i = `BCH_N - 1; i >= 0; i--)
		begin
			if (gaps && i < `BCH_N - 1)
				idle_cycles(int'(rand_bits(2)));
			@(posedge I_clk);
			#0.5;
			in_v = 1'b1;
			in_sof = (i == `BCH_N - 1);
			in_bit = tx[i];
		end
		// latency counts from the cycle of the last bit
		exp_word_q.push_back(cw);
		exp_cnt_q.push_back(n_err);
		last_cyc_q.push_back(cyc);
		frames_sent++;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (frames_done < frames_sent && waited < DRAIN_LIMIT)
		begin
			@(posedge I_clk);
			waited++;
		end
		if (frames_done < frames_sent)
		begin
			$display("missing output frame: %0d sent, %0d received", frames_sent, frames_done);
			errors++;
		end
	endtask

	task automatic run_test(input string name, input int n_frames, input int kind);
		logic [`BCH_N-1:0] tx;
		logic [`BCH_N-1:0] cw;
		int n_err;
		int err_before;
		err_before = errors;
		for (int f = 0; f < n_frames; f++)
		begin
			case (kind)
				KIND_CLEAN: n_err = 0;
				KIND_ERR:   n_err = f % `BCH_T + 1;
				default:    n_err = int'(rand_bits(2));
			endcase
			build_frame(n_err, tx, cw);
			send_frame(tx, cw, n_err, kind == KIND_GAPS);
			if (kind != KIND_B2B)
				idle_cycles(2);
		end
		idle_cycles(1);
		wait_drain();
		n_tests++;
		$display("test %0d %s: %0d frames, %0d errors", n_tests, name, n_frames,
			errors - err_before);
	endtask

	initial
	begin
		arst_n = 1'b0;
		in_bit = 1'b0;
		in_v = 1'b0;
		in_sof = 1'b0;
		repeat (8) @(posedge I_clk);
		#0.5;
		arst_n = 1'b1;
		// outputs must stay quiet here
		idle_cycles(10);
		run_test("reset state and latency", 1, KIND_CLEAN);
		run_test("error-free frames", 20, KIND_CLEAN);
		run_test("one to three errors", 60, KIND_ERR);
		run_test("back-to-back frames", 30, KIND_B2B);
		run_test("gapped input bits", 20, KIND_GAPS);
		$display("summary: %0d tests, %0d frames checked, %0d errors", n_tests, frames_done,
			errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* bch_dec.f */
+incdir+include
verilog/bch_pkg.sv
verilog/bch_syndrome.sv
verilog/bch_bm.sv
verilog/bch_chien.sv
verilog/bch_dec.sv
bench/bch_clk_gen.sv
bench/bch_dec_tb.sv

/* Bender.yml */
package:
  name: bch_dec

sources:
  - include_dirs:
      - include
    files:
      - verilog/bch_pkg.sv
      - verilog/bch_syndrome.sv
      - verilog/bch_bm.sv
      - verilog/bch_chien.sv
      - verilog/bch_dec.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/bch_clk_gen.sv
      - bench/bch_dec_tb.sv
